// ==== bht_table.sv ====
`timescale 1ns/1ps

module bht_table (
	input  logic clk,
	input  logic wr_en,
	input  logic [bp_cfg_pkg::IDX_W-1:0] wr_idx,
	input  logic [bp_ctr_pkg::CTR_W-1:0] wr_ctr,
	input  logic [bp_cfg_pkg::IDX_W-1:0] rd_idx,
	input  logic [bp_cfg_pkg::HIST_BITS-1:0] hist,
	input  logic en,
	input  logic init_busy,
	input  logic [bp_cfg_pkg::PC_W-1:0] fetch_pc [bp_cfg_pkg::FETCH_PORTS],
	output logic [bp_ctr_pkg::CTR_W-1:0] rd_ctr,
	output logic [bp_cfg_pkg::FETCH_PORTS-1:0] predict_taken
);
	import bp_cfg_pkg::*;
	import bp_ctr_pkg::*;

	// counter storage, contents set by the clear sweep
	logic [CTR_W-1:0] bht_mem [BHT_DEPTH];

	logic [IDX_W-1:0] fetch_idx [FETCH_PORTS];
	logic [CTR_W-1:0] fetch_ctr [FETCH_PORTS];

	// predictions are only meaningful once the sweep is done
	logic pred_ok;

	// ==================================================
	// write port
	// ==================================================

	always_ff @(posedge clk) begin
		if (wr_en)
			bht_mem[wr_idx] <= wr_ctr;
	end

	// ==================================================
	// read ports
	// ==================================================

	// update path reads the entry it is about to write
	assign rd_ctr = bht_mem[rd_idx];

	assign pred_ok = en && !init_busy;

	// fetch slots index with address bits above history
	always_comb begin
		for (int f = 0; f < FETCH_PORTS; f++) begin
			fetch_idx[f] = {fetch_pc[f][PC_IDX_LSB +: PC_IDX_BITS], hist};
			fetch_ctr[f] = bht_mem[fetch_idx[f]];
			predict_taken[f] = CTR_TAKEN_MASK[fetch_ctr[f]] && pred_ok;
		end
	end

endmodule

// ==== bp_cfg_pkg.sv ====
package bp_cfg_pkg;

	// ==================================================
	// port widths and counts
	// ==================================================

	// fetch and commit address width
	localparam int PC_W = 32;
	// resolved branches per cycle from commit
	localparam int COMMIT_PORTS = 3;
	// fetch slots that want a prediction
	localparam int FETCH_PORTS = 6;

	// ==================================================
	// table indexing
	// ==================================================

	// bit 0 of the address is skipped
	localparam int PC_IDX_LSB = 1;
	localparam int PC_IDX_BITS = 7;
	// global history bits in the low end of the index
	localparam int HIST_BITS = 2;
	localparam int IDX_W = PC_IDX_BITS + HIST_BITS;
	localparam int BHT_DEPTH = 1 << IDX_W;

	// ==================================================
	// commit queue
	// ==================================================

	// one slot stays unused, equal pointers mean empty
	localparam int QUEUE_DEPTH = 32;
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);
	// index bits on top, taken bit at 0
	localparam int ENTRY_W = PC_IDX_BITS + 1;

endpackage

// ==== bp_ctr_pkg.sv ====
package bp_ctr_pkg;

	// ==================================================
	// two bit counter encoding
	// ==================================================

	localparam int CTR_W = 2;

	// rotated encoding, the chain runs
	// strong nt -> weak nt -> weak t -> strong t
	// which is a plain +1 step modulo 4
	localparam logic [CTR_W-1:0] CTR_STRONG_T = 2'd1;
	localparam logic [CTR_W-1:0] CTR_WEAK_T = 2'd0;
	localparam logic [CTR_W-1:0] CTR_WEAK_NT = 2'd3;
	localparam logic [CTR_W-1:0] CTR_STRONG_NT = 2'd2;

	// written to every entry by the clear sweep
	localparam logic [CTR_W-1:0] CTR_RESET = CTR_WEAK_NT;

	// ==================================================
	// taken decision
	// ==================================================

	// one bit per counter value, set where the value predicts taken
	// bit 0 is weak taken, bit 1 is strong taken
	localparam logic [(1 << CTR_W)-1:0] CTR_TAKEN_MASK =
		(4'b0001 << CTR_WEAK_T) | (4'b0001 << CTR_STRONG_T);

endpackage

// ==== branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor (
	input  logic clk,
	input  logic rst,
	input  logic en,
	input  logic [bp_cfg_pkg::COMMIT_PORTS-1:0] commit_valid,
	input  logic [bp_cfg_pkg::PC_W-1:0] commit_pc [bp_cfg_pkg::COMMIT_PORTS],
	input  logic [bp_cfg_pkg::COMMIT_PORTS-1:0] commit_taken,
	input  logic [bp_cfg_pkg::PC_W-1:0] fetch_pc [bp_cfg_pkg::FETCH_PORTS],
	output logic [bp_cfg_pkg::FETCH_PORTS-1:0] predict_taken,
	output logic queue_overflow,
	output logic init_busy
);
	import bp_cfg_pkg::*;
	import bp_ctr_pkg::*;

	// queue to update stage
	logic pop_valid;
	logic [PC_IDX_BITS-1:0] pop_idx;
	logic pop_taken;

	// update stage to table
	logic [IDX_W-1:0] rd_idx;
	logic [CTR_W-1:0] rd_ctr;
	logic wr_en;
	logic [IDX_W-1:0] wr_idx;
	logic [CTR_W-1:0] wr_ctr;
	logic [HIST_BITS-1:0] hist;

	// ==================================================
	// stage 1, pending updates
	// ==================================================

	commit_queue u_commit_queue (
		.clk            (clk),
		.rst            (rst),
		.en             (en),
		.init_busy      (init_busy),
		.commit_valid   (commit_valid),
		.commit_pc      (commit_pc),
		.commit_taken   (commit_taken),
		.pop_valid      (pop_valid),
		.pop_idx        (pop_idx),
		.pop_taken      (pop_taken),
		.queue_overflow (queue_overflow)
	);

	// stage 2, counter step, history and clear sweep
	counter_update u_counter_update (
		.clk       (clk),
		.rst       (rst),
		.en        (en),
		.pop_valid (pop_valid),
		.pop_idx   (pop_idx),
		.pop_taken (pop_taken),
		.rd_ctr    (rd_ctr),
		.rd_idx    (rd_idx),
		.wr_en     (wr_en),
		.wr_idx    (wr_idx),
		.wr_ctr    (wr_ctr),
		.hist      (hist),
		.init_busy (init_busy)
	);

	// stage 3, table write and fetch lookups
	bht_table u_bht_table (
		.clk           (clk),
		.wr_en         (wr_en),
		.wr_idx        (wr_idx),
		.wr_ctr        (wr_ctr),
		.rd_idx        (rd_idx),
		.hist          (hist),
		.en            (en),
		.init_busy     (init_busy),
		.fetch_pc      (fetch_pc),
		.rd_ctr        (rd_ctr),
		.predict_taken (predict_taken)
	);

endmodule

// ==== commit_queue.sv ====
`timescale 1ns/1ps

module commit_queue (
	input  logic clk,
	input  logic rst,
	input  logic en,
	input  logic init_busy,
	input  logic [bp_cfg_pkg::COMMIT_PORTS-1:0] commit_valid,
	input  logic [bp_cfg_pkg::PC_W-1:0] commit_pc [bp_cfg_pkg::COMMIT_PORTS],
	input  logic [bp_cfg_pkg::COMMIT_PORTS-1:0] commit_taken,
	output logic pop_valid,
	output logic [bp_cfg_pkg::PC_IDX_BITS-1:0] pop_idx,
	output logic pop_taken,
	output logic queue_overflow
);
	import bp_cfg_pkg::*;

	// circular buffer of pending updates
	logic [ENTRY_W-1:0] q_mem [QUEUE_DEPTH];
	logic [QPTR_W-1:0] head;
	logic [QPTR_W-1:0] tail;

	// occupancy and space left
	logic [QPTR_W-1:0] used_cnt;
	logic [QPTR_W-1:0] free_cnt;

	// per port packing results
	logic [ENTRY_W-1:0] port_entry [COMMIT_PORTS];
	logic [QPTR_W-1:0] slot_ptr [COMMIT_PORTS];
	logic [COMMIT_PORTS-1:0] accept;
	logic [QPTR_W-1:0] push_cnt;
	logic drop;

	logic [ENTRY_W-1:0] head_entry;

	// ==================================================
	// packing of the commit ports
	// ==================================================

	// pointer difference wraps, so this is the live count
	assign used_cnt = tail - head;
	assign free_cnt = QPTR_W'(QUEUE_DEPTH - 1) - used_cnt;

	// valid ports take consecutive slots in port order
	// once space runs out the younger ports are dropped
	always_comb begin
		push_cnt = '0;
		drop = 1'b0;
		for (int p = 0; p < COMMIT_PORTS; p++) begin
			port_entry[p] = {commit_pc[p][PC_IDX_LSB +: PC_IDX_BITS], commit_taken[p]};
			slot_ptr[p] = tail + push_cnt;
			accept[p] = 1'b0;
			if (commit_valid[p]) begin
				if (push_cnt < free_cnt) begin
					accept[p] = 1'b1;
					push_cnt = push_cnt + 1'b1;
				end else begin
					drop = 1'b1;
				end
			end
		end
	end

	// accepted ports land in their packed slots
	always_ff @(posedge clk) begin
		for (int p = 0; p < COMMIT_PORTS; p++) begin
			if (accept[p])
				q_mem[slot_ptr[p]] <= port_entry[p];
		end
	end

	// ==================================================
	// pointers and pop
	// ==================================================

	// no pops while stalled or while the table is being cleared
	assign pop_valid = en && !init_busy && (head != tail);
	assign head_entry = q_mem[head];
	assign pop_idx = head_entry[ENTRY_W-1:1];
	assign pop_taken = head_entry[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			queue_overflow <= 1'b0;
		end else begin
			tail <= tail + push_cnt;
			if (pop_valid)
				head <= head + 1'b1;
			// flag follows the cycle that lost entries
			queue_overflow <= drop;
		end
	end

endmodule

// ==== counter_update.sv ====
`timescale 1ns/1ps

module counter_update (
	input  logic clk,
	input  logic rst,
	input  logic en,
	input  logic pop_valid,
	input  logic [bp_cfg_pkg::PC_IDX_BITS-1:0] pop_idx,
	input  logic pop_taken,
	input  logic [bp_ctr_pkg::CTR_W-1:0] rd_ctr,
	output logic [bp_cfg_pkg::IDX_W-1:0] rd_idx,
	output logic wr_en,
	output logic [bp_cfg_pkg::IDX_W-1:0] wr_idx,
	output logic [bp_ctr_pkg::CTR_W-1:0] wr_ctr,
	output logic [bp_cfg_pkg::HIST_BITS-1:0] hist,
	output logic init_busy
);
	import bp_cfg_pkg::*;
	import bp_ctr_pkg::*;

	// entry in flight between pop and table write
	logic upd_valid;
	logic [PC_IDX_BITS-1:0] upd_idx;
	logic upd_taken;

	// clear sweep address
	logic [IDX_W-1:0] clr_idx;

	logic [IDX_W-1:0] upd_wr_idx;
	logic [CTR_W-1:0] ctr_next;

	// ==================================================
	// update register and history
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			upd_valid <= 1'b0;
			hist <= '0;
		end else if (en) begin
			// pop only happens with en high, so this is one entry per cycle
			upd_valid <= pop_valid;
			// history moves as the held entry is written
			if (upd_valid)
				hist <= {hist[HIST_BITS-2:0], upd_taken};
		end
	end

	// held entry payload, loaded on every pop
	always_ff @(posedge clk) begin
		if (pop_valid) begin
			upd_idx <= pop_idx;
			upd_taken <= pop_taken;
		end
	end

	// ==================================================
	// clear sweep
	// ==================================================

	// one entry per cycle, busy drops after the last write
	always_ff @(posedge clk) begin
		if (rst) begin
			clr_idx <= '0;
			init_busy <= 1'b1;
		end else if (init_busy) begin
			clr_idx <= clr_idx + 1'b1;
			if (clr_idx == IDX_W'(BHT_DEPTH - 1))
				init_busy <= 1'b0;
		end
	end

	// ==================================================
	// saturating counter step
	// ==================================================

	// current history, so back-to-back entries see the previous shift
	assign upd_wr_idx = {upd_idx, hist};
	assign rd_idx = upd_wr_idx;

	always_comb begin
		case (rd_ctr)
			CTR_STRONG_NT: ctr_next = upd_taken ? CTR_WEAK_NT : CTR_STRONG_NT;
			CTR_WEAK_NT:   ctr_next = upd_taken ? CTR_WEAK_T : CTR_STRONG_NT;
			CTR_WEAK_T:    ctr_next = upd_taken ? CTR_STRONG_T : CTR_WEAK_NT;
			default:       ctr_next = upd_taken ? CTR_STRONG_T : CTR_WEAK_T;
		endcase
	end

	// sweep owns the write port until it is done
	assign wr_en = init_busy || (upd_valid && en);
	assign wr_idx = init_busy ? clr_idx : upd_wr_idx;
	assign wr_ctr = init_busy ? CTR_RESET : ctr_next;

endmodule

// ==== list.f ====
bp_cfg_pkg.sv
bp_ctr_pkg.sv
commit_queue.sv
counter_update.sv
bht_table.sv
branch_predictor.sv
tb_clock.sv
tb_branch_predictor.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_branch_predictor -o sim_tb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
echo "pass message not found"
exit 1

// ==== tb_branch_predictor.sv ====
`timescale 1ns/1ps

module tb_branch_predictor;
	import bp_cfg_pkg::*;

	// clear sweep plus every test's traffic and drain time, with margin
	localparam int CYCLE_LIMIT = 2500;

	logic clk;
	logic rst;
	logic en;
	logic [COMMIT_PORTS-1:0] commit_valid;
	logic [PC_W-1:0] commit_pc [COMMIT_PORTS];
	logic [COMMIT_PORTS-1:0] commit_taken;
	logic [PC_W-1:0] fetch_pc [FETCH_PORTS];
	logic [FETCH_PORTS-1:0] predict_taken;
	logic queue_overflow;
	logic init_busy;

	// staged values for the next cycle, and what sits on the pins now
	logic nxt_en;
	logic [COMMIT_PORTS-1:0] nxt_valid;
	logic [PC_W-1:0] nxt_pc [COMMIT_PORTS];
	logic [COMMIT_PORTS-1:0] nxt_taken;
	logic [PC_W-1:0] nxt_fetch [FETCH_PORTS];
	logic cur_en;
	logic [PC_W-1:0] cur_fetch [FETCH_PORTS];

	// ==================================================
	// reference model
	// ==================================================

	// counter strength, 0 strong nt up to 3 strong t
	int lvl [BHT_DEPTH];
	logic [HIST_BITS-1:0] mhist;
	// pending updates, index bits on top and taken at bit 0
	logic [ENTRY_W-1:0] mq [$];
	logic exp_ovf;
	logic sweep_done;

	int seed;
	int err_cnt;
	int tests_run;
	int tests_ok;
	int ovf_seen;
	int cycle_cnt = 0;

	tb_clock u_clock (.clk(clk), .rst(rst));

	branch_predictor UUT (
		.clk            (clk),
		.rst            (rst),
		.en             (en),
		.commit_valid   (commit_valid),
		.commit_pc      (commit_pc),
		.commit_taken   (commit_taken),
		.fetch_pc       (fetch_pc),
		.predict_taken  (predict_taken),
		.queue_overflow (queue_overflow),
		.init_busy      (init_busy)
	);

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic void report_mismatch(input string sig, input logic [31:0] exp,
			input logic [31:0] got);
		$display("** Error at %0t: %s expected %0d got %0d", $time, sig, exp, got);
		err_cnt++;
	endfunction

	task automatic finish_test(input string name, input int start_err);
		tests_run++;
		if (err_cnt == start_err) begin
			tests_ok++;
			$display("%s: ok", name);
		end else
			$display("%s: %0d errors", name, err_cnt - start_err);
	endtask

	// one update, indexed with the history it sees, then history shifts
	function automatic void apply_entry(input logic [ENTRY_W-1:0] e);
		logic [IDX_W-1:0] idx;
		idx = {e[ENTRY_W-1:1], mhist};
		if (e[0] && lvl[idx] < 3)
			lvl[idx]++;
		else if (!e[0] && lvl[idx] > 0)
			lvl[idx]--;
		mhist = {mhist[HIST_BITS-2:0], e[0]};
	endfunction

	function automatic logic model_pred(input logic [PC_W-1:0] pc);
		logic [IDX_W-1:0] idx;
		idx = {pc[PC_IDX_LSB +: PC_IDX_BITS], mhist};
		return cur_en && sweep_done && (lvl[idx] >= 2);
	endfunction

	// queue as seen at the edge ending this cycle, space is taken before the pop
	task automatic model_step();
		int free_slots;
		logic pop;
		logic [ENTRY_W-1:0] e;
		pop = cur_en && (mq.size() > 0);
		free_slots = (QUEUE_DEPTH - 1) - mq.size();
		exp_ovf = 1'b0;
		for (int p = 0; p < COMMIT_PORTS; p++) begin
			if (nxt_valid[p] && free_slots > 0) begin
				mq.push_back({nxt_pc[p][PC_IDX_LSB +: PC_IDX_BITS], nxt_taken[p]});
				free_slots--;
			end else if (nxt_valid[p])
				exp_ovf = 1'b1;
		end
		if (pop) begin
			e = mq.pop_front();
			apply_entry(e);
		end
	endtask

	task automatic check_fetch();
		for (int f = 0; f < FETCH_PORTS; f++) begin
			if (predict_taken[f] !== model_pred(cur_fetch[f]))
				report_mismatch($sformatf("predict_taken[%0d]", f),
					32'(model_pred(cur_fetch[f])), 32'(predict_taken[f]));
		end
	endtask

	// ==================================================
	// cycle driver
	// ==================================================

	// drive at the rising edge, sample mid cycle
	task automatic tick(input logic chk);
		@(posedge clk);
		en <= nxt_en;
		commit_valid <= nxt_valid;
		commit_taken <= nxt_taken;
		for (int p = 0; p < COMMIT_PORTS; p++)
			commit_pc[p] <= nxt_pc[p];
		for (int f = 0; f < FETCH_PORTS; f++) begin
			fetch_pc[f] <= nxt_fetch[f];
			cur_fetch[f] = nxt_fetch[f];
		end
		cur_en = nxt_en;
		@(negedge clk);
		if (queue_overflow !== exp_ovf)
			report_mismatch("queue_overflow", 32'(exp_ovf), 32'(queue_overflow));
		if (queue_overflow === 1'b1)
			ovf_seen++;
		// model still holds the state before this cycle's pop
		if (chk)
			check_fetch();
		model_step();
		nxt_valid = '0;
	endtask

	// last pop, then one edge for the register and one for the write
	task automatic drain();
		nxt_en = 1'b1;
		while (mq.size() > 0)
			tick(1'b0);
		tick(1'b0);
		tick(1'b0);
	endtask

	task automatic sweep_check();
		logic [PC_W-1:0] pc;
		for (int base = 0; base < (1 << PC_IDX_BITS); base += FETCH_PORTS) begin
			for (int f = 0; f < FETCH_PORTS; f++) begin
				pc = $random(seed);
				pc[PC_IDX_LSB +: PC_IDX_BITS] = PC_IDX_BITS'(base + f);
				nxt_fetch[f] = pc;
			end
			tick(1'b1);
		end
	endtask

	// ==================================================
	// tests
	// ==================================================

	task automatic reset_and_clear();
		int start_err;
		int busy_cycles;
		start_err = err_cnt;
		busy_cycles = 0;
		nxt_en = 1'b1;
		cur_en = 1'b1;
		@(posedge clk);
		en <= 1'b1;
		for (int f = 0; f < FETCH_PORTS; f++)
			fetch_pc[f] <= $random(seed);
		@(negedge clk);
		while (rst)
			@(negedge clk);
		// en is high, so only the sweep holds predictions low
		while (init_busy) begin
			if (predict_taken !== '0)
				report_mismatch("predict_taken", 0, 32'(predict_taken));
			if (queue_overflow !== 1'b0)
				report_mismatch("queue_overflow", 0, 32'(queue_overflow));
			busy_cycles++;
			@(negedge clk);
		end
		if (busy_cycles != BHT_DEPTH)
			report_mismatch("init_busy high cycles", BHT_DEPTH, busy_cycles);
		sweep_done = 1'b1;
		sweep_check();
		finish_test("reset and clear", start_err);
	endtask

	task automatic train_one_address();
		int start_err;
		start_err = err_cnt;
		for (int f = 0; f < FETCH_PORTS; f++)
			nxt_fetch[f] = 32'h0000_3046;
		for (int i = 0; i < 12; i++) begin
			nxt_valid = 3'b001;
			nxt_pc[0] = 32'h0000_3046;
			nxt_taken = (i < 6) ? 3'b001 : 3'b000;
			tick(1'b0);
			drain();
			// strong taken at history 11 after six taken, strong nt at 00 after six nt
			if (i == 5 || i == 11) begin
				tick(1'b1);
				if (predict_taken[0] !== (i == 5))
					report_mismatch("predict_taken[0]", 32'(i == 5), 32'(predict_taken[0]));
			end
		end
		sweep_check();
		finish_test("training", start_err);
	endtask

	task automatic multi_port_order();
		int start_err;
		start_err = err_cnt;
		// ports 0 and 2 share an address, so the order shows in the counters
		for (int c = 0; c < 4; c++) begin
			nxt_valid = 3'b111;
			for (int p = 0; p < COMMIT_PORTS; p++)
				nxt_pc[p] = 32'(((p % 2) + 1) << 1);
			nxt_taken = 3'(c + 3);
			tick(1'b0);
		end
		drain();
		sweep_check();
		finish_test("multi-port ordering", start_err);
	endtask

	task automatic enable_stall();
		int start_err;
		start_err = err_cnt;
		nxt_en = 1'b0;
		for (int i = 0; i < 5; i++) begin
			nxt_valid = 3'b011;
			nxt_pc[0] = 32'((5 + i) << 1);
			nxt_pc[1] = 32'((6 + i) << 1);
			nxt_taken = 3'b011;
			tick(1'b1);
			if (predict_taken !== '0)
				report_mismatch("predict_taken", 0, 32'(predict_taken));
		end
		// first enabled cycle still shows the table from before the stall
		nxt_en = 1'b1;
		for (int f = 0; f < FETCH_PORTS; f++)
			nxt_fetch[f] = 32'((5 + f) << 1);
		tick(1'b1);
		drain();
		tick(1'b1);
		sweep_check();
		finish_test("enable stall", start_err);
	endtask

	task automatic overflow_drop();
		int start_err;
		start_err = err_cnt;
		ovf_seen = 0;
		nxt_en = 1'b0;
		// 11 bursts of three, the last burst keeps only port 0
		for (int b = 0; b < 11; b++) begin
			nxt_valid = 3'b111;
			for (int p = 0; p < COMMIT_PORTS; p++)
				nxt_pc[p] = 32'((80 + b * 3 + p) << 1);
			nxt_taken = 3'b111;
			tick(1'b0);
		end
		drain();
		if (ovf_seen != 1)
			report_mismatch("queue_overflow pulses", 1, ovf_seen);
		// dropped entries 111 and 112 never trained
		for (int f = 0; f < FETCH_PORTS; f++)
			nxt_fetch[f] = 32'((111 + f) << 1);
		tick(1'b1);
		if (predict_taken[1:0] !== 2'b00)
			report_mismatch("predict_taken[1:0]", 0, 32'(predict_taken[1:0]));
		sweep_check();
		finish_test("overflow", start_err);
	endtask

	task automatic random_traffic();
		int start_err;
		start_err = err_cnt;
		for (int blk = 0; blk < 4; blk++) begin
			for (int c = 0; c < 50; c++) begin
				nxt_en = (($random(seed) & 7) != 0);
				nxt_valid = COMMIT_PORTS'($random(seed));
				nxt_taken = COMMIT_PORTS'($random(seed));
				for (int p = 0; p < COMMIT_PORTS; p++)
					nxt_pc[p] = $random(seed);
				tick(1'b0);
			end
			drain();
			for (int c = 0; c < 8; c++) begin
				for (int f = 0; f < FETCH_PORTS; f++)
					nxt_fetch[f] = $random(seed);
				tick(1'b1);
			end
		end
		finish_test("random traffic", start_err);
	endtask

	initial begin
		seed = 9418;
		err_cnt = 0;
		tests_run = 0;
		tests_ok = 0;
		ovf_seen = 0;
		en <= 1'b0;
		commit_valid <= '0;
		commit_taken <= '0;
		for (int p = 0; p < COMMIT_PORTS; p++) begin
			commit_pc[p] <= '0;
			nxt_pc[p] = '0;
		end
		for (int f = 0; f < FETCH_PORTS; f++) begin
			fetch_pc[f] <= '0;
			nxt_fetch[f] = '0;
		end
		nxt_valid = '0;
		nxt_taken = '0;
		nxt_en = 1'b0;
		// every entry starts at weak not-taken once the sweep is done
		for (int i = 0; i < BHT_DEPTH; i++)
			lvl[i] = 1;
		mhist = '0;
		exp_ovf = 1'b0;
		sweep_done = 1'b0;
		reset_and_clear();
		train_one_address();
		multi_port_order();
		enable_stall();
		overflow_drop();
		random_traffic();
		$display("tests run %0d, passed %0d, errors %0d", tests_run, tests_ok, err_cnt);
		if (err_cnt == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset held over the first four rising edges
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

endmodule
